// File: armIsaPkg.sv
package armIsaPkg;

  // Full word width and the slice the control unit sees
  localparam int unsigned instrW = 32;
  localparam int unsigned instrHiW = 20;

  // Field positions, numbered as in the full instruction word
  localparam int unsigned condMsb = 31;
  localparam int unsigned condLsb = 28;
  localparam int unsigned opMsb = 27;
  localparam int unsigned opLsb = 26;
  localparam int unsigned iBitPos = 25;
  localparam int unsigned cmdMsb = 24;
  localparam int unsigned cmdLsb = 21;
  // S for data processing, L for memory
  localparam int unsigned slBitPos = 20;
  localparam int unsigned rdMsb = 15;
  localparam int unsigned rdLsb = 12;

  localparam int unsigned immSrcW = 2;
  localparam int unsigned regSrcW = 2;
  localparam int unsigned flagWW = 2;

  localparam logic [rdMsb-rdLsb:0] pcReg = 15;

  typedef enum logic [1:0] {
    opDataProc = 2'b00,
    opMemory   = 2'b01,
    opBranch   = 2'b10
  } opT;

  typedef enum logic [3:0] {
    cmdAnd = 4'b0000,
    cmdSub = 4'b0010,
    cmdAdd = 4'b0100,
    cmdOrr = 4'b1100
  } cmdT;

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluCtlT;

endpackage

// File: armCondPkg.sv
package armCondPkg;

  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condCs = 4'b0010,
    condCc = 4'b0011,
    condMi = 4'b0100,
    condPl = 4'b0101,
    condVs = 4'b0110,
    condVc = 4'b0111,
    condHi = 4'b1000,
    condLs = 4'b1001,
    condGe = 4'b1010,
    condLt = 4'b1011,
    condGt = 4'b1100,
    condLe = 4'b1101,
    condAl = 4'b1110
  } condT;

  // Stored flags, NZCV from msb down
  typedef logic [3:0] flagsT;

  localparam int unsigned flagBitN = 3;
  localparam int unsigned flagBitZ = 2;
  localparam int unsigned flagBitC = 1;
  localparam int unsigned flagBitV = 0;

endpackage

// File: decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
  import armIsaPkg::*;

  // Bit 1 requests N and Z, bit 0 requests C and V
  logic [flagWW-1:0] flagW;
  logic pcS;
  logic regW;
  logic memW;

  modport decoder (
    output flagW,
    output pcS,
    output regW,
    output memW
  );

  modport cond (
    input flagW,
    input pcS,
    input regW,
    input memW
  );

endinterface

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic [armIsaPkg::instrW-1:armIsaPkg::instrW-armIsaPkg::instrHiW] instr,
  decodeIf.decoder                           ctl,
  output logic [armIsaPkg::regSrcW-1:0]      regSrc,
  output logic [armIsaPkg::immSrcW-1:0]      immSrc,
  output logic                               aluSrc,
  output armIsaPkg::aluCtlT                  aluControl,
  output logic                               memToReg
);
  import armIsaPkg::*;

  opT                 op;
  cmdT                cmd;
  logic               iBit;
  logic               slBit;
  logic [rdMsb-rdLsb:0] rd;

  logic               regW;
  logic               memW;
  logic               branch;
  logic               aluOp;
  logic [flagWW-1:0]  flagW;

  assign op    = opT'(instr[opMsb:opLsb]);
  assign cmd   = cmdT'(instr[cmdMsb:cmdLsb]);
  assign iBit  = instr[iBitPos];
  assign slBit = instr[slBitPos];
  assign rd    = instr[rdMsb:rdLsb];

  // Main decoder
  always_comb begin
    regW     = 1'b0;
    memW     = 1'b0;
    memToReg = 1'b0;
    aluSrc   = 1'b0;
    immSrc   = 2'b00;
    regSrc   = 2'b00;
    branch   = 1'b0;
    aluOp    = 1'b0;
    case (op)
      opDataProc: begin
        regW   = 1'b1;
        aluSrc = iBit;
        aluOp  = 1'b1;
      end
      opMemory: begin
        aluSrc = 1'b1;
        immSrc = 2'b01;
        if (slBit) begin
          // LDR
          regW     = 1'b1;
          memToReg = 1'b1;
        end else begin
          // STR reads Rd as the store data
          memW   = 1'b1;
          regSrc = 2'b10;
        end
      end
      opBranch: begin
        aluSrc = 1'b1;
        immSrc = 2'b10;
        regSrc = 2'b01;
        branch = 1'b1;
      end
      default: begin
        // Op 11 is unsupported, all requests stay low
        regW = 1'b0;
      end
    endcase
  end

  // ALU decoder
  always_comb begin
    aluControl = aluAdd;
    flagW      = 2'b00;
    if (aluOp) begin
      case (cmd)
        cmdAdd:  aluControl = aluAdd;
        cmdSub:  aluControl = aluSub;
        cmdAnd:  aluControl = aluAnd;
        cmdOrr:  aluControl = aluOrr;
        default: aluControl = aluAdd;
      endcase
      if (slBit) begin
        flagW[1] = 1'b1;
        // Logic ops leave C and V alone
        flagW[0] = (cmd == cmdAdd) || (cmd == cmdSub);
      end
    end
  end

  assign ctl.regW  = regW;
  assign ctl.memW  = memW;
  assign ctl.flagW = flagW;
  // Branch or write to r15
  assign ctl.pcS   = branch || (regW && (rd == pcReg));

endmodule

// File: condLogic.sv
`timescale 1ns/1ps

module condLogic (
  input  logic               clk,
  input  logic               arstN,
  input  armCondPkg::condT   cond,
  input  armCondPkg::flagsT  aluFlags,
  decodeIf.cond              ctl,
  output logic               regWrite,
  output logic               memWrite,
  output logic               pcSrc
);
  import armCondPkg::*;

  flagsT flags;
  logic  n;
  logic  z;
  logic  c;
  logic  v;
  logic  condEx;

  assign n = flags[flagBitN];
  assign z = flags[flagBitZ];
  assign c = flags[flagBitC];
  assign v = flags[flagBitV];

  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = !z;
      condCs:  condEx = c;
      condCc:  condEx = !c;
      condMi:  condEx = n;
      condPl:  condEx = !n;
      condVs:  condEx = v;
      condVc:  condEx = !v;
      condHi:  condEx = c && !z;
      condLs:  condEx = !c || z;
      condGe:  condEx = (n == v);
      condLt:  condEx = (n != v);
      condGt:  condEx = !z && (n == v);
      condLe:  condEx = z || (n != v);
      condAl:  condEx = 1'b1;
      // Code 1111 is not part of this subset
      default: condEx = 1'b0;
    endcase
  end

  // NZ and CV flag pairs are written separately
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else begin
      if (ctl.flagW[1] && condEx) begin
        flags[flagBitN] <= aluFlags[flagBitN];
        flags[flagBitZ] <= aluFlags[flagBitZ];
      end
      if (ctl.flagW[0] && condEx) begin
        flags[flagBitC] <= aluFlags[flagBitC];
        flags[flagBitV] <= aluFlags[flagBitV];
      end
    end
  end

  assign regWrite = ctl.regW && condEx;
  assign memWrite = ctl.memW && condEx;
  assign pcSrc    = ctl.pcS && condEx;

  // The decoder never asks for a register and a memory write together
  assert property (@(posedge clk) disable iff (!arstN)
    !(ctl.regW && ctl.memW))
    else $error("register and memory write requested together");

  // No flag request, no flag change on the next edge
  assert property (@(posedge clk) disable iff (!arstN)
    (ctl.flagW == 2'b00) |=> $stable(flags))
    else $error("flags changed without a write request");

endmodule

// File: controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic [armIsaPkg::instrW-1:armIsaPkg::instrW-armIsaPkg::instrHiW] instr,
  input  armCondPkg::flagsT                   aluFlags,
  output logic [armIsaPkg::regSrcW-1:0]       regSrc,
  output logic                                regWrite,
  output logic [armIsaPkg::immSrcW-1:0]       immSrc,
  output logic                                aluSrc,
  output armIsaPkg::aluCtlT                   aluControl,
  output logic                                memWrite,
  output logic                                memToReg,
  output logic                                pcSrc
);
  import armIsaPkg::*;
  import armCondPkg::*;

  condT cond;

  decodeIf ctlBus ();

  assign cond = condT'(instr[condMsb:condLsb]);

  instrDecoder uDecoder (
    .instr      (instr),
    .ctl        (ctlBus.decoder),
    .regSrc     (regSrc),
    .immSrc     (immSrc),
    .aluSrc     (aluSrc),
    .aluControl (aluControl),
    .memToReg   (memToReg)
  );

  // Flags and conditional gating of the write requests
  condLogic uCond (
    .clk      (clk),
    .arstN    (arstN),
    .cond     (cond),
    .aluFlags (aluFlags),
    .ctl      (ctlBus.cond),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .pcSrc    (pcSrc)
  );

endmodule

// File: controlUnit_tb.sv
`timescale 1ns/1ps

module controlUnit_tb;
  import armIsaPkg::*;
  import armCondPkg::*;

  localparam int unsigned clkPeriodNs = 100;
  localparam int unsigned resetCycles = 4;
  localparam int unsigned directedCount = 30;
  localparam int unsigned randomCount = 300;
  localparam int unsigned marginCycles = 66;
  localparam int unsigned timeoutNs =
    (resetCycles + directedCount + randomCount + marginCycles) * clkPeriodNs;
  // Byte select of a load or store
  localparam int unsigned byteBitPos = 22;

  typedef logic [instrW-1:instrW-instrHiW] instrHiT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic       regWrite;
    logic [1:0] immSrc;
    logic       aluSrc;
    aluCtlT     aluControl;
    logic       memWrite;
    logic       memToReg;
    logic       pcSrc;
  } ctlT;

  logic      clk;
  logic      arstN;
  instrHiT   instr;
  flagsT     aluFlags;
  logic [1:0] regSrc;
  logic      regWrite;
  logic [1:0] immSrc;
  logic      aluSrc;
  aluCtlT    aluControl;
  logic      memWrite;
  logic      memToReg;
  logic      pcSrc;

  flagsT     modelFlags;
  logic      checkEn;

  controlUnit u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .instr      (instr),
    .aluFlags   (aluFlags),
    .regSrc     (regSrc),
    .regWrite   (regWrite),
    .immSrc     (immSrc),
    .aluSrc     (aluSrc),
    .aluControl (aluControl),
    .memWrite   (memWrite),
    .memToReg   (memToReg),
    .pcSrc      (pcSrc)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  // ARM style: the low cond bit inverts the base test
  function automatic logic condPasses(input logic [3:0] c, input flagsT f);
    logic base;
    case (c[3:1])
      3'b000:  base = f[flagBitZ];
      3'b001:  base = f[flagBitC];
      3'b010:  base = f[flagBitN];
      3'b011:  base = f[flagBitV];
      3'b100:  base = f[flagBitC] && !f[flagBitZ];
      3'b101:  base = f[flagBitN] == f[flagBitV];
      3'b110:  base = !f[flagBitZ] && (f[flagBitN] == f[flagBitV]);
      default: base = 1'b1;
    endcase
    return base ^ c[0];
  endfunction

  function automatic logic [1:0] flagWrites(input instrHiT ins);
    logic [3:0] cmd;
    cmd = ins[cmdMsb:cmdLsb];
    if (ins[opMsb:opLsb] != opDataProc || !ins[slBitPos]) begin
      return 2'b00;
    end
    return {1'b1, (cmd == cmdAdd) || (cmd == cmdSub)};
  endfunction

  function automatic ctlT expectedCtl(input instrHiT ins, input flagsT f);
    ctlT e;
    logic [1:0] op;
    logic pass;
    logic regW;
    logic memW;
    logic pcS;
    op = ins[opMsb:opLsb];
    pass = condPasses(ins[condMsb:condLsb], f);
    e = '0;
    e.aluControl = aluAdd;
    regW = 1'b0;
    memW = 1'b0;
    pcS = 1'b0;
    if (op == opDataProc) begin
      regW = 1'b1;
      e.aluSrc = ins[iBitPos];
      case (ins[cmdMsb:cmdLsb])
        cmdSub:  e.aluControl = aluSub;
        cmdAnd:  e.aluControl = aluAnd;
        cmdOrr:  e.aluControl = aluOrr;
        default: e.aluControl = aluAdd;
      endcase
    end else if (op == opMemory) begin
      e.aluSrc = 1'b1;
      e.immSrc = 2'b01;
      if (ins[slBitPos]) begin
        regW = 1'b1;
        e.memToReg = 1'b1;
      end else begin
        memW = 1'b1;
        e.regSrc = 2'b10;
      end
    end else if (op == opBranch) begin
      e.aluSrc = 1'b1;
      e.immSrc = 2'b10;
      e.regSrc = 2'b01;
      pcS = 1'b1;
    end
    pcS = pcS || (regW && (ins[rdMsb:rdLsb] == 4'hf));
    e.regWrite = regW && pass;
    e.memWrite = memW && pass;
    e.pcSrc = pcS && pass;
    return e;
  endfunction

  function automatic instrHiT makeDp(input logic [3:0] c, input logic i, input cmdT cmd,
                                     input logic s, input logic [3:0] rd);
    instrHiT w;
    w = '0;
    w[condMsb:condLsb] = c;
    w[opMsb:opLsb] = opDataProc;
    w[iBitPos] = i;
    w[cmdMsb:cmdLsb] = cmd;
    w[slBitPos] = s;
    w[19:16] = 4'd2;
    w[rdMsb:rdLsb] = rd;
    return w;
  endfunction

  function automatic instrHiT makeMem(input logic [3:0] c, input logic l,
                                      input logic [3:0] rd);
    instrHiT w;
    w = '0;
    w[condMsb:condLsb] = c;
    w[opMsb:opLsb] = opMemory;
    // Pre-indexed, offset added
    w[24] = 1'b1;
    w[23] = 1'b1;
    w[slBitPos] = l;
    w[19:16] = 4'd3;
    w[rdMsb:rdLsb] = rd;
    return w;
  endfunction

  function automatic instrHiT makeBr(input logic [3:0] c);
    instrHiT w;
    w = '0;
    w[condMsb:condLsb] = c;
    w[opMsb:opLsb] = opBranch;
    w[iBitPos] = 1'b1;
    w[23:12] = 12'h3c5;
    return w;
  endfunction

  function automatic instrHiT randomInstr();
    instrHiT w;
    logic [1:0] op;
    w = 20'($urandom);
    w[condMsb:condLsb] = 4'($urandom_range(14, 0));
    op = 2'($urandom_range(2, 0));
    w[opMsb:opLsb] = op;
    if (op == opDataProc) begin
      case ($urandom_range(3, 0))
        0:       w[cmdMsb:cmdLsb] = cmdAnd;
        1:       w[cmdMsb:cmdLsb] = cmdSub;
        2:       w[cmdMsb:cmdLsb] = cmdAdd;
        default: w[cmdMsb:cmdLsb] = cmdOrr;
      endcase
    end else if (op == opMemory) begin
      // Word access with an immediate offset only
      w[iBitPos] = 1'b0;
      w[byteBitPos] = 1'b0;
    end
    if ($urandom_range(3, 0) == 0) begin
      w[rdMsb:rdLsb] = 4'hf;
    end
    return w;
  endfunction

  task automatic checkVal(input string name, input logic [3:0] exp, input logic [3:0] act);
    assert (act === exp) else begin
      $display("mismatch at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic compareOutputs();
    ctlT e;
    e = expectedCtl(instr, modelFlags);
    checkVal("regSrc", 4'(e.regSrc), 4'(regSrc));
    checkVal("regWrite", 4'(e.regWrite), 4'(regWrite));
    checkVal("immSrc", 4'(e.immSrc), 4'(immSrc));
    checkVal("aluSrc", 4'(e.aluSrc), 4'(aluSrc));
    checkVal("aluControl", 4'(e.aluControl), 4'(aluControl));
    checkVal("memWrite", 4'(e.memWrite), 4'(memWrite));
    checkVal("memToReg", 4'(e.memToReg), 4'(memToReg));
    checkVal("pcSrc", 4'(e.pcSrc), 4'(pcSrc));
  endtask

  task automatic drive(input instrHiT ins, input logic [3:0] fl);
    @(negedge clk);
    instr = ins;
    aluFlags = fl;
  endtask

  // Hand-written expectations on top of the model
  task automatic expectWrites(input logic rw, input logic mw, input logic pc);
    #30;
    checkVal("regWrite", 4'(rw), 4'(regWrite));
    checkVal("memWrite", 4'(mw), 4'(memWrite));
    checkVal("pcSrc", 4'(pc), 4'(pcSrc));
  endtask

  // Flag model, updated on the same edge as the DUT
  always @(posedge clk or negedge arstN) begin : flagModel
    logic [1:0] fw;
    fw = flagWrites(instr);
    if (!arstN) begin
      modelFlags <= '0;
    end else if (condPasses(instr[condMsb:condLsb], modelFlags)) begin
      if (fw[1]) begin
        modelFlags[flagBitN] <= aluFlags[flagBitN];
        modelFlags[flagBitZ] <= aluFlags[flagBitZ];
      end
      if (fw[0]) begin
        modelFlags[flagBitC] <= aluFlags[flagBitC];
        modelFlags[flagBitV] <= aluFlags[flagBitV];
      end
    end
  end

  always @(negedge clk) begin
    #20;
    if (checkEn) begin
      compareOutputs();
    end
  end

  initial begin
    #(timeoutNs);
    $display("timeout: the stimulus did not complete in the expected time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    void'($urandom(32'h76a27a89));
    arstN = 1'b0;
    instr = '0;
    aluFlags = '0;
    checkEn = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    checkEn = 1'b1;

    // Cleared flags, EQ fails and NE passes
    drive(makeDp(condEq, 1'b0, cmdAdd, 1'b0, 4'd1), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b0);
    drive(makeDp(condNe, 1'b0, cmdAdd, 1'b0, 4'd1), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b0);

    drive(makeDp(condAl, 1'b0, cmdAdd, 1'b0, 4'd2), 4'h5);
    drive(makeDp(condAl, 1'b1, cmdAdd, 1'b0, 4'd3), 4'h5);
    drive(makeDp(condAl, 1'b0, cmdSub, 1'b0, 4'd4), 4'ha);
    drive(makeDp(condAl, 1'b1, cmdSub, 1'b0, 4'd5), 4'ha);
    drive(makeDp(condAl, 1'b0, cmdAnd, 1'b0, 4'd6), 4'hf);
    drive(makeDp(condAl, 1'b1, cmdAnd, 1'b0, 4'd7), 4'hf);
    drive(makeDp(condAl, 1'b0, cmdOrr, 1'b0, 4'd8), 4'h3);
    drive(makeDp(condAl, 1'b1, cmdOrr, 1'b0, 4'd9), 4'h3);

    drive(makeMem(condAl, 1'b0, 4'd4), 4'h0);
    expectWrites(1'b0, 1'b1, 1'b0);
    drive(makeMem(condAl, 1'b1, 4'd5), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b0);
    drive(makeBr(condAl), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b1);
    drive(makeDp(condAl, 1'b0, cmdAdd, 1'b0, 4'hf), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b1);

    // ADDS sets Z
    drive(makeDp(condAl, 1'b0, cmdAdd, 1'b1, 4'd1), 4'b0100);
    drive(makeDp(condEq, 1'b0, cmdOrr, 1'b0, 4'd2), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b0);
    // SUBS with N and C set, V clear
    drive(makeDp(condAl, 1'b1, cmdSub, 1'b1, 4'd3), 4'b1010);
    drive(makeBr(condLt), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b1);
    drive(makeMem(condGe, 1'b0, 4'd6), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b0);
    drive(makeMem(condCs, 1'b1, 4'd7), 4'h0);
    // ANDS must keep C and V from the SUBS
    drive(makeDp(condAl, 1'b0, cmdAnd, 1'b1, 4'd8), 4'b0011);
    drive(makeDp(condCs, 1'b0, cmdAdd, 1'b0, 4'd9), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b0);
    drive(makeDp(condVc, 1'b0, cmdAdd, 1'b0, 4'd9), 4'h0);
    expectWrites(1'b1, 1'b0, 1'b0);
    drive(makeDp(condNe, 1'b0, cmdSub, 1'b0, 4'd10), 4'h0);
    drive(makeDp(condMi, 1'b0, cmdOrr, 1'b0, 4'd11), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b0);
    // ORRS sets N and Z
    drive(makeDp(condAl, 1'b1, cmdOrr, 1'b1, 4'd12), 4'b1101);
    drive(makeBr(condLe), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b1);
    drive(makeDp(condGt, 1'b0, cmdAdd, 1'b0, 4'hf), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b0);
    drive(makeMem(condHi, 1'b0, 4'd1), 4'h0);
    expectWrites(1'b0, 1'b0, 1'b0);
    drive(makeBr(condAl), 4'h0);

    repeat (randomCount) begin
      drive(randomInstr(), 4'($urandom));
    end
    #40;
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: list.f
armIsaPkg.sv
armCondPkg.sv
decodeIf.sv
instrDecoder.sv
condLogic.sv
controlUnit.sv
controlUnit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module controlUnit_tb \
  -o simControlUnit || { echo "Build error"; exit 1; }
simOut=$(./obj_dir/simControlUnit 2>&1)
echo "$simOut"
# Pass only if the testbench printed its pass line
echo "$simOut" | grep -qx "Simulation passed" && echo "Run result: PASS" ||
  { echo "Run result: FAIL"; exit 1; }
